// File: source/tlb_defs.svh
`ifndef TLB_DEFS_SVH
`define TLB_DEFS_SVH

// sizing of the two page levels and of the miss queue.

// sets in the 4 KiB page level.
`define TLB_SETS0 16

// sets in the 4 MiB superpage level.
`define TLB_SETS1 4

// ways per set, shared by both levels.
`define TLB_WAYS 2

// pending misses waiting for the walker.
`define MISSQ_DEPTH 4

`endif

// File: source/sv32_pkg.sv
package sv32_pkg;

    localparam int OFFSET_W = 12; // page offset bits.

    typedef struct packed {
        logic [9:0] vpn1;
        logic [9:0] vpn0;
    } vpn_t;

    typedef logic [31:0] vaddr_t;

    typedef logic [33:0] paddr_t;

    typedef struct packed {
        logic [11:0] ppn1;
        logic [9:0]  ppn0;
    } ppn_t;

    typedef struct packed {
        ppn_t       ppn;
        logic [1:0] rsw;
        logic       d;
        logic       a;
        logic       g;
        logic       u;
        logic       x;
        logic       w;
        logic       r;
        logic       v;
    } pte_t;

endpackage

// File: source/mmu_req_pkg.sv
package mmu_req_pkg;

    // bit 0 marks a read and bit 1 a write, so a fetch has neither set.
    typedef enum logic [1:0] {
        ACC_FETCH = 2'b00,
        ACC_LOAD  = 2'b01,
        ACC_STORE = 2'b10
    } access_t;

    typedef enum logic [1:0] {
        PRIV_U = 2'b00,
        PRIV_S = 2'b01
    } priv_t;

    typedef enum logic [1:0] {
        RESP_HIT   = 2'b00,
        RESP_MISS  = 2'b01,
        RESP_FAULT = 2'b10,
        RESP_RETRY = 2'b11
    } resp_status_t;

endpackage

// File: source/tlb_page.sv
`include "tlb_defs.svh"

module tlb_page #(
    parameter int LEVEL = 0,
    parameter int SETS  = 16
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           lookup_valid,
    input  sv32_pkg::vpn_t lookup_vpn,
    input  logic           refill_valid,
    input  logic           refill_level,
    input  sv32_pkg::vpn_t refill_vpn,
    input  sv32_pkg::pte_t refill_pte,
    input  logic           fence,
    output logic           hit,
    output sv32_pkg::pte_t hit_pte
);
    import sv32_pkg::*;

    localparam int   WAYS      = `TLB_WAYS;
    localparam int   KEY_W     = (LEVEL == 1) ? 10 : 20; // a superpage is named by vpn1 only.
    localparam int   IDX_W     = $clog2(SETS);
    localparam int   TAG_W     = KEY_W - IDX_W;
    localparam int   WAY_W     = $clog2(WAYS);
    localparam logic LEVEL_BIT = (LEVEL == 1);

    logic [TAG_W-1:0] tag_mem [SETS][WAYS];
    pte_t             pte_mem [SETS][WAYS];
    logic [WAYS-1:0]  valid_q [SETS];
    logic [WAY_W-1:0] victim_q [SETS];

    logic [KEY_W-1:0] lookup_key;
    logic [KEY_W-1:0] refill_key;
    logic [IDX_W-1:0] lookup_idx;
    logic [TAG_W-1:0] lookup_tag;
    logic [IDX_W-1:0] refill_idx;
    logic [TAG_W-1:0] refill_tag;
    logic [WAY_W-1:0] victim;
    logic [WAY_W-1:0] next_victim;
    logic [WAYS-1:0]  match;
    logic             refill_hit;
    pte_t             sel_pte;

    assign lookup_key = lookup_vpn[19 -: KEY_W];
    assign refill_key = refill_vpn[19 -: KEY_W];
    assign lookup_idx = lookup_key[IDX_W-1:0];
    assign lookup_tag = lookup_key[KEY_W-1:IDX_W];
    assign refill_idx = refill_key[IDX_W-1:0];
    assign refill_tag = refill_key[KEY_W-1:IDX_W];

    assign refill_hit  = refill_valid && (refill_level == LEVEL_BIT);
    assign victim      = victim_q[refill_idx];
    assign next_victim = (victim == WAY_W'(WAYS - 1)) ? '0 : victim + 1'b1;

    always_comb begin
        match   = '0;
        sel_pte = pte_mem[lookup_idx][0];
        for (int w = WAYS - 1; w >= 0; w--) begin // walk down so the lowest hitting way wins.
            match[w] = valid_q[lookup_idx][w] && (tag_mem[lookup_idx][w] == lookup_tag);
            if (match[w]) begin
                sel_pte = pte_mem[lookup_idx][w];
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            hit <= 1'b0;
            for (int s = 0; s < SETS; s++) begin
                valid_q[s]  <= '0;
                victim_q[s] <= '0;
            end
        end else begin
            hit <= lookup_valid && (|match);
            if (fence) begin
                for (int s = 0; s < SETS; s++) begin
                    valid_q[s] <= '0;
                end
            end
            if (refill_hit) begin // placed after the fence clear so a same-cycle refill survives.
                valid_q[refill_idx][victim] <= 1'b1;
                victim_q[refill_idx]        <= next_victim;
            end
        end
    end

    always_ff @(posedge clk) begin
        hit_pte <= sel_pte;
        if (refill_hit) begin
            tag_mem[refill_idx][victim] <= refill_tag;
            pte_mem[refill_idx][victim] <= refill_pte;
        end
    end

endmodule

// File: source/pte_check.sv
module pte_check (
    input  sv32_pkg::pte_t      pte,
    input  logic                superpage,
    input  sv32_pkg::vaddr_t    vaddr,
    input  mmu_req_pkg::access_t access,
    input  mmu_req_pkg::priv_t  priv,
    input  logic                sum,
    input  logic                mxr,
    output logic                fault,
    output sv32_pkg::paddr_t    paddr
);
    import sv32_pkg::*;
    import mmu_req_pkg::*;

    logic is_load;
    logic is_store;
    logic is_fetch;
    logic bad_pte;
    logic perm_ok;
    logic mode_fault;
    logic ad_fault;
    logic misaligned;

    assign is_load  = (access == ACC_LOAD);
    assign is_store = (access == ACC_STORE);
    assign is_fetch = (access == ACC_FETCH);

    assign bad_pte = ~pte.v | (pte.w & ~pte.r) | (|pte.rsw);

    // mxr lets a load read an execute-only page.
    assign perm_ok = (is_load & (pte.r | (pte.x & mxr))) |
                     (is_store & pte.w) |
                     (is_fetch & pte.x);

    assign mode_fault = ((priv == PRIV_U) & ~pte.u) |
                        ((priv == PRIV_S) & pte.u & ~sum);

    assign ad_fault   = ~pte.a | (is_store & ~pte.d);
    assign misaligned = superpage & (|pte.ppn.ppn0); // a superpage must sit on a 4 MiB boundary.

    assign fault = bad_pte | ~perm_ok | mode_fault | ad_fault | misaligned;

    always_comb begin
        if (superpage) begin
            paddr = {pte.ppn.ppn1, vaddr[21:OFFSET_W], vaddr[OFFSET_W-1:0]};
        end else begin
            paddr = {pte.ppn, vaddr[OFFSET_W-1:0]};
        end
    end

endmodule

// File: source/req_queue.sv
module req_queue #(
    parameter int DEPTH = 4
) (
    input  logic           clk,
    input  logic           rst,
    input  logic           push,
    input  sv32_pkg::vpn_t push_vpn,
    input  logic           pop,
    output sv32_pkg::vpn_t head_vpn,
    output logic           empty,
    output logic           full
);
    import sv32_pkg::*;

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    vpn_t             mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    assign head_vpn = mem[rd_ptr]; // the head is readable before the pop.
    assign empty    = (count == '0);
    assign full     = (count == CNT_W'(DEPTH));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_W'(push) - CNT_W'(pop);
        end
    end

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_vpn;
        end
    end

    a_no_overflow : assert property (@(posedge clk) disable iff (rst) !(push && full));
    a_no_underflow : assert property (@(posedge clk) disable iff (rst) !(pop && empty));

endmodule

// File: source/walk_port.sv
module walk_port (
    input  logic           clk,
    input  logic           rst,
    input  logic           empty,
    input  sv32_pkg::vpn_t head_vpn,
    input  logic           walk_ack,
    input  sv32_pkg::pte_t walk_pte,
    input  logic           walk_level,
    output logic           pop,
    output logic           walk_req,
    output sv32_pkg::vpn_t walk_vpn,
    output logic           refill_valid,
    output sv32_pkg::vpn_t refill_vpn,
    output logic           refill_level,
    output sv32_pkg::pte_t refill_pte
);
    typedef enum logic [1:0] {
        IDLE,
        REQUEST,
        RELEASE,
        REFILL
    } state_t;

    state_t state;

    assign pop          = (state == IDLE) && !empty;
    assign walk_req     = (state == REQUEST);
    assign refill_valid = (state == REFILL);
    assign refill_vpn   = walk_vpn; // the walked vpn names the entry to refill.

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (pop) state <= REQUEST;
                REQUEST: if (walk_ack) state <= RELEASE;
                RELEASE: if (!walk_ack) state <= REFILL; // wait for the walker to finish its half.
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (pop) begin
            walk_vpn <= head_vpn;
        end
        if (walk_req && walk_ack) begin
            refill_pte   <= walk_pte;
            refill_level <= walk_level;
        end
    end

    a_ack_needs_req : assert property (@(posedge clk) disable iff (rst)
        $rose(walk_ack) |-> walk_req);

endmodule

// File: source/tlb_lookup.sv
`include "tlb_defs.svh"

module tlb_lookup (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       lookup_valid,
    input  sv32_pkg::vaddr_t           lookup_vaddr,
    input  mmu_req_pkg::access_t       lookup_access,
    input  mmu_req_pkg::priv_t         priv,
    input  logic                       sum,
    input  logic                       mxr,
    input  logic                       fence,
    input  logic                       full,
    input  logic                       refill_valid,
    input  sv32_pkg::vpn_t             refill_vpn,
    input  logic                       refill_level,
    input  sv32_pkg::pte_t             refill_pte,
    output logic                       resp_valid,
    output mmu_req_pkg::resp_status_t  resp_status,
    output sv32_pkg::paddr_t           resp_paddr,
    output sv32_pkg::vaddr_t           resp_vaddr,
    output logic                       push,
    output sv32_pkg::vpn_t             push_vpn
);
    import sv32_pkg::*;
    import mmu_req_pkg::*;

    logic    s1_valid;
    vaddr_t  s1_vaddr;
    access_t s1_access;
    logic    pg0_hit;
    logic    pg1_hit;
    pte_t    pg0_pte;
    pte_t    pg1_pte;
    pte_t    sel_pte;
    logic    chk_fault;
    paddr_t  chk_paddr;
    logic    s2_miss;
    logic    s2_fault;

    tlb_page #(.LEVEL(0), .SETS(`TLB_SETS0)) u_page0 (
        .clk(clk), .rst(rst),
        .lookup_valid(lookup_valid), .lookup_vpn(lookup_vaddr[31:OFFSET_W]),
        .refill_valid(refill_valid), .refill_level(refill_level),
        .refill_vpn(refill_vpn), .refill_pte(refill_pte),
        .fence(fence), .hit(pg0_hit), .hit_pte(pg0_pte)
    );

    tlb_page #(.LEVEL(1), .SETS(`TLB_SETS1)) u_page1 (
        .clk(clk), .rst(rst),
        .lookup_valid(lookup_valid), .lookup_vpn(lookup_vaddr[31:OFFSET_W]),
        .refill_valid(refill_valid), .refill_level(refill_level),
        .refill_vpn(refill_vpn), .refill_pte(refill_pte),
        .fence(fence), .hit(pg1_hit), .hit_pte(pg1_pte)
    );

    assign sel_pte = pg0_hit ? pg0_pte : pg1_pte; // a 4 KiB entry wins over a superpage.

    pte_check u_check (
        .pte(sel_pte), .superpage(!pg0_hit), .vaddr(s1_vaddr),
        .access(s1_access), .priv(priv), .sum(sum), .mxr(mxr),
        .fault(chk_fault), .paddr(chk_paddr)
    );

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_valid   <= 1'b0;
            resp_valid <= 1'b0;
        end else begin
            s1_valid   <= lookup_valid;
            resp_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_vaddr   <= lookup_vaddr;
        s1_access  <= lookup_access;
        s2_miss    <= !(pg0_hit || pg1_hit);
        s2_fault   <= chk_fault;
        resp_paddr <= chk_paddr;
        resp_vaddr <= s1_vaddr;
    end

    // full is looked at in the response cycle, so a miss turns into retry here.
    always_comb begin
        if (s2_miss) begin
            resp_status = full ? RESP_RETRY : RESP_MISS;
        end else begin
            resp_status = s2_fault ? RESP_FAULT : RESP_HIT;
        end
    end

    assign push     = resp_valid && s2_miss && !full;
    assign push_vpn = resp_vaddr[31:OFFSET_W];

endmodule

// File: source/l2_tlb.sv
`include "tlb_defs.svh"

module l2_tlb (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      lookup_valid,
    input  sv32_pkg::vaddr_t          lookup_vaddr,
    input  mmu_req_pkg::access_t      lookup_access,
    output logic                      resp_valid,
    output mmu_req_pkg::resp_status_t resp_status,
    output sv32_pkg::paddr_t          resp_paddr,
    output sv32_pkg::vaddr_t          resp_vaddr,
    input  mmu_req_pkg::priv_t        priv,
    input  logic                      sum,
    input  logic                      mxr,
    input  logic                      fence,
    output logic                      walk_req,
    output sv32_pkg::vpn_t            walk_vpn,
    input  logic                      walk_ack,
    input  sv32_pkg::pte_t            walk_pte,
    input  logic                      walk_level
);
    import sv32_pkg::*;

    logic push;
    vpn_t push_vpn;
    logic pop;
    vpn_t head_vpn;
    logic empty;
    logic full;
    logic refill_valid;
    vpn_t refill_vpn;
    logic refill_level;
    pte_t refill_pte;

    tlb_lookup u_lookup (
        .clk(clk), .rst(rst),
        .lookup_valid(lookup_valid), .lookup_vaddr(lookup_vaddr),
        .lookup_access(lookup_access), .priv(priv), .sum(sum), .mxr(mxr),
        .fence(fence), .full(full),
        .refill_valid(refill_valid), .refill_vpn(refill_vpn),
        .refill_level(refill_level), .refill_pte(refill_pte),
        .resp_valid(resp_valid), .resp_status(resp_status),
        .resp_paddr(resp_paddr), .resp_vaddr(resp_vaddr),
        .push(push), .push_vpn(push_vpn)
    );

    req_queue #(.DEPTH(`MISSQ_DEPTH)) u_queue (
        .clk(clk), .rst(rst),
        .push(push), .push_vpn(push_vpn), .pop(pop),
        .head_vpn(head_vpn), .empty(empty), .full(full)
    );

    walk_port u_walk (
        .clk(clk), .rst(rst),
        .empty(empty), .head_vpn(head_vpn),
        .walk_ack(walk_ack), .walk_pte(walk_pte), .walk_level(walk_level),
        .pop(pop), .walk_req(walk_req), .walk_vpn(walk_vpn),
        .refill_valid(refill_valid), .refill_vpn(refill_vpn),
        .refill_level(refill_level), .refill_pte(refill_pte)
    );

endmodule

// File: bench/tb_ref.svh
`ifndef TB_REF_SVH
`define TB_REF_SVH

// the page table model picks a superpage by vpn1[9] and takes flags as {d,a,u,x,w,r}.
function automatic logic [32:0] page_table(input vpn_t vpn);
    pte_t pte;
    logic is_super;
    is_super = vpn.vpn1[9];
    pte      = '0;
    pte.v    = 1'b1;
    if (is_super) begin
        {pte.d, pte.a, pte.u, pte.x, pte.w, pte.r} = vpn.vpn1[7:2];
        pte.ppn.ppn1 = {2'b01, vpn.vpn1 ^ 10'h1b3};
        pte.ppn.ppn0 = vpn.vpn1[8] ? 10'h004 : 10'h000; // vpn1[8] asks for a misaligned leaf.
    end else begin
        {pte.d, pte.a, pte.u, pte.x, pte.w, pte.r} = vpn.vpn0[9:4];
        pte.ppn.ppn1 = {2'b10, vpn.vpn1 ^ 10'h2a7};
        pte.ppn.ppn0 = vpn.vpn0 ^ 10'h13c;
    end
    return {is_super, pte};
endfunction

// expected status and physical address of a lookup whose leaf is cached.
function automatic resp_status_t ref_translate(input vaddr_t va, input access_t acc,
                                               input priv_t pv, input logic sm,
                                               input logic mx, output paddr_t pa);
    logic [32:0] entry;
    pte_t        pte;
    logic        lvl;
    logic        bad;
    entry = page_table(va[31:12]);
    lvl   = entry[32];
    pte   = entry[31:0];
    bad   = !pte.v || (pte.w && !pte.r) || (pte.rsw != 2'b00);
    if (acc == ACC_LOAD && !(pte.r || (mx && pte.x))) bad = 1'b1;
    if (acc == ACC_STORE && !pte.w) bad = 1'b1;
    if (acc == ACC_FETCH && !pte.x) bad = 1'b1;
    if (pv == PRIV_U && !pte.u) bad = 1'b1;
    if (pv == PRIV_S && pte.u && !sm) bad = 1'b1;
    if (!pte.a || (acc == ACC_STORE && !pte.d)) bad = 1'b1;
    if (lvl && pte.ppn.ppn0 != 10'h000) bad = 1'b1;
    pa = lvl ? {pte.ppn.ppn1, va[21:0]} : {pte.ppn, va[11:0]};
    return bad ? RESP_FAULT : RESP_HIT;
endfunction

`endif

// File: bench/tb_l2_tlb.sv
`include "tlb_defs.svh"

module tb_l2_tlb;
    import sv32_pkg::*;
    import mmu_req_pkg::*;

    `include "tb_ref.svh"

    localparam int K_XLATE    = 0;
    localparam int K_MISS     = 1;
    localparam int K_RETRY    = 2;
    localparam int WAIT_LIMIT = 200;
    localparam int BP_COUNT   = `MISSQ_DEPTH + 3;

    logic         clk;
    logic         rst;
    logic         lookup_valid;
    vaddr_t       lookup_vaddr;
    access_t      lookup_access;
    logic         resp_valid;
    resp_status_t resp_status;
    paddr_t       resp_paddr;
    vaddr_t       resp_vaddr;
    priv_t        priv;
    logic         sum;
    logic         mxr;
    logic         fence;
    logic         walk_req;
    vpn_t         walk_vpn;
    logic         walk_ack;
    pte_t         walk_pte;
    logic         walk_level;

    integer       seed = 73;
    int           cycle = 0;
    int           walks_done = 0;
    logic         stall = 1'b0;
    string        exp_name [$];
    resp_status_t exp_status [$];
    paddr_t       exp_paddr [$];
    vaddr_t       exp_vaddr [$];
    int           exp_cycle [$];
    vpn_t         walk_exp [$];

    l2_tlb DUT (
        .clk(clk), .rst(rst),
        .lookup_valid(lookup_valid), .lookup_vaddr(lookup_vaddr),
        .lookup_access(lookup_access),
        .resp_valid(resp_valid), .resp_status(resp_status),
        .resp_paddr(resp_paddr), .resp_vaddr(resp_vaddr),
        .priv(priv), .sum(sum), .mxr(mxr), .fence(fence),
        .walk_req(walk_req), .walk_vpn(walk_vpn),
        .walk_ack(walk_ack), .walk_pte(walk_pte), .walk_level(walk_level)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    task automatic stop_on_error(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check(input string name, input logic [63:0] expected,
                         input logic [63:0] actual);
        if (expected !== actual) begin
            stop_on_error($sformatf("** Error %s: expected %0h, actual %0h",
                                    name, expected, actual));
        end
    endtask

    function automatic vaddr_t addr4k(input logic [8:0] vpn1, input logic [5:0] flags,
                                      input logic [3:0] set, input logic [11:0] off);
        return {1'b0, vpn1, flags, set, off};
    endfunction

    function automatic vaddr_t addr_sp(input logic misal, input logic [5:0] flags,
                                       input logic [1:0] set, input logic [21:0] off);
        return {1'b1, misal, flags, set, off};
    endfunction

    // drives one lookup on the current falling edge and records what it must answer.
    task automatic issue(input string name, input vaddr_t va, input access_t acc,
                         input int kind);
        resp_status_t st;
        paddr_t       pa;
        st = ref_translate(va, acc, priv, sum, mxr, pa);
        if (kind == K_MISS) begin
            st = RESP_MISS;
            walk_exp.push_back(va[31:OFFSET_W]);
        end else if (kind == K_RETRY) begin
            st = RESP_RETRY;
        end
        lookup_valid  = 1'b1;
        lookup_vaddr  = va;
        lookup_access = acc;
        exp_name.push_back(name);
        exp_status.push_back(st);
        exp_paddr.push_back(pa);
        exp_vaddr.push_back(va);
        exp_cycle.push_back(cycle);
        @(negedge clk);
        lookup_valid = 1'b0;
    endtask

    task automatic wait_walks(input int target);
        int n;
        n = 0;
        while (walks_done < target) begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) stop_on_error("timeout waiting for a page walk to finish");
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (exp_status.size() != 0) begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) stop_on_error("timeout waiting for outstanding responses");
        end
    endtask

    task automatic set_mode(input priv_t pv, input logic sm, input logic mx);
        wait_drain();
        priv = pv;
        sum  = sm;
        mxr  = mx;
    endtask

    // first lookup misses, the walk refills, the repeat follows the reference.
    task automatic touch(input string name, input vaddr_t va, input access_t acc);
        int target;
        target = walks_done + 1;
        issue({name, " miss"}, va, acc, K_MISS);
        wait_walks(target);
        repeat (2) @(negedge clk);
        issue(name, va, acc, K_XLATE);
    endtask

    initial begin : walker
        int   delay;
        int   n;
        vpn_t exp_vpn;
        walk_ack   = 1'b0;
        walk_pte   = '0;
        walk_level = 1'b0;
        forever begin
            @(negedge clk);
            if (!rst && walk_req && !walk_ack && !stall) begin
                if (walk_exp.size() == 0) begin
                    stop_on_error("a page walk started with no miss outstanding");
                end else begin
                    exp_vpn = walk_exp.pop_front();
                    check("walk vpn", 64'(exp_vpn), 64'(walk_vpn));
                end
                delay = $random(seed) & 3;
                repeat (delay) @(negedge clk);
                {walk_level, walk_pte} = page_table(walk_vpn);
                walk_ack = 1'b1;
                n = 0;
                while (walk_req) begin
                    @(negedge clk);
                    n++;
                    if (n > WAIT_LIMIT) stop_on_error("timeout waiting for walk_req to fall");
                end
                walk_ack = 1'b0;
                walks_done++;
            end
        end
    end

    initial begin : compare
        string        name;
        resp_status_t st;
        paddr_t       pa;
        vaddr_t       va;
        int           issued;
        forever begin
            @(negedge clk);
            if (!rst && resp_valid) begin
                if (exp_status.size() == 0) begin
                    stop_on_error("a response arrived with no lookup outstanding");
                end else begin
                    name   = exp_name.pop_front();
                    st     = exp_status.pop_front();
                    pa     = exp_paddr.pop_front();
                    va     = exp_vaddr.pop_front();
                    issued = exp_cycle.pop_front();
                    check({name, " latency"}, 64'd2, 64'(cycle - issued));
                    check({name, " status"}, 64'(st), 64'(resp_status));
                    check({name, " vaddr"}, 64'(va), 64'(resp_vaddr));
                    if (st == RESP_HIT || st == RESP_FAULT) begin
                        check({name, " paddr"}, 64'(pa), 64'(resp_paddr));
                    end
                end
            end
        end
    end

    initial begin : stimulus
        vaddr_t va_rwx;
        vaddr_t va_sp;
        vaddr_t va_ro;
        vaddr_t va_xo;
        vaddr_t va_user;
        vaddr_t va_nod;
        vaddr_t bp_addr [BP_COUNT];
        int     target;
        rst           = 1'b1;
        lookup_valid  = 1'b0;
        lookup_vaddr  = '0;
        lookup_access = ACC_LOAD;
        priv          = PRIV_S;
        sum           = 1'b0;
        mxr           = 1'b0;
        fence         = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check("reset resp_valid", 64'd0, 64'(resp_valid));
        check("reset walk_req", 64'd0, 64'(walk_req));

        va_rwx  = addr4k(9'h05a, 6'b110111, 4'h1, 12'h345);
        va_sp   = addr_sp(1'b0, 6'b110111, 2'h1, 22'h2abcde);
        va_ro   = addr4k(9'h033, 6'b110001, 4'h2, 12'h010);
        va_xo   = addr4k(9'h044, 6'b110100, 4'h3, 12'h020);
        va_user = addr4k(9'h066, 6'b111111, 4'h5, 12'h040);
        va_nod  = addr4k(9'h088, 6'b010111, 4'h7, 12'h060);

        touch("4k load", va_rwx, ACC_LOAD);
        issue("4k store", va_rwx, ACC_STORE, K_XLATE);
        touch("super load", va_sp, ACC_LOAD);
        issue("super fetch", va_sp, ACC_FETCH, K_XLATE);
        touch("super misaligned", addr_sp(1'b1, 6'b110111, 2'h2, 22'h01f00f), ACC_LOAD);

        touch("read-only load", va_ro, ACC_LOAD);
        issue("read-only store", va_ro, ACC_STORE, K_XLATE);
        issue("read-only fetch", va_ro, ACC_FETCH, K_XLATE);
        touch("exec-only fetch", va_xo, ACC_FETCH);
        issue("exec-only load", va_xo, ACC_LOAD, K_XLATE);
        set_mode(PRIV_S, 1'b0, 1'b1);
        issue("exec-only load mxr", va_xo, ACC_LOAD, K_XLATE);
        set_mode(PRIV_S, 1'b0, 1'b0);
        touch("write-only store", addr4k(9'h055, 6'b110010, 4'h4, 12'h030), ACC_STORE);
        touch("user page from s", va_user, ACC_LOAD);
        set_mode(PRIV_S, 1'b1, 1'b0);
        issue("user page with sum", va_user, ACC_LOAD, K_XLATE);
        set_mode(PRIV_U, 1'b0, 1'b0);
        issue("user page from u", va_user, ACC_STORE, K_XLATE);
        issue("s page from u", va_rwx, ACC_LOAD, K_XLATE);
        set_mode(PRIV_S, 1'b0, 1'b0);
        touch("accessed clear", addr4k(9'h077, 6'b100111, 4'h6, 12'h050), ACC_LOAD);
        touch("dirty clear load", va_nod, ACC_LOAD);
        issue("dirty clear store", va_nod, ACC_STORE, K_XLATE);

        // walker held off, so the queue plus the walk port absorb the misses.
        wait_drain();
        stall  = 1'b1;
        target = walks_done + `MISSQ_DEPTH + 1;
        for (int i = 0; i < BP_COUNT; i++) begin
            bp_addr[i] = addr4k(9'h100 + 9'(i), 6'b110111, 4'(8 + i), 12'h100);
            issue($sformatf("backpressure %0d", i), bp_addr[i], ACC_LOAD,
                  (i <= `MISSQ_DEPTH) ? K_MISS : K_RETRY);
        end
        wait_drain();
        stall = 1'b0;
        wait_walks(target);
        repeat (2) @(negedge clk);
        issue("backpressure refill first", bp_addr[0], ACC_LOAD, K_XLATE);
        issue("backpressure refill last", bp_addr[`MISSQ_DEPTH], ACC_LOAD, K_XLATE);

        wait_drain();
        fence = 1'b1;
        issue("fence in flight", bp_addr[0], ACC_LOAD, K_XLATE); // compared before the clear.
        fence = 1'b0;
        issue("after fence 4k", bp_addr[0], ACC_LOAD, K_MISS);
        issue("after fence super", va_sp, ACC_LOAD, K_MISS);
        wait_drain();

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

// File: all.f
+incdir+source
+incdir+bench
source/sv32_pkg.sv
source/mmu_req_pkg.sv
source/tlb_page.sv
source/pte_check.sv
source/req_queue.sv
source/walk_port.sv
source/tlb_lookup.sv
source/l2_tlb.sv
bench/tb_l2_tlb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_l2_tlb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation completed successfully

SOURCES := $(wildcard source/*.sv source/*.svh bench/*.sv bench/*.svh)
SIM     := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(SIM)

$(OBJ_DIR)/V%: $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $* --Mdir $(OBJ_DIR)

run: $(SIM)
	@out="$$(./$(SIM) 2>&1)"; echo "$$out"; echo "$$out" | grep -qF "$(PASS_MSG)"

check: $(SIM)
	@out="$$(./$(SIM) 2>&1)"; echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
